// ==== files.f ====
rtl/dfa_pkg.sv
rtl/scan_pkg.sv
rtl/dfa_engine.sv
rtl/scan_ingress.sv
rtl/stream_context.sv
rtl/verdict_egress.sv
rtl/pattern_scanner_top.sv
dv/tb_pattern_scanner.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_pattern_scanner
RTL_TOP   ?= pattern_scanner_top
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Simulation FAILED" $(LOG); then \
		echo "Run failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/tb_pattern_scanner.sv ====
module tb_pattern_scanner;

   import scan_pkg::*;
   import dfa_pkg::*;

   localparam int CLK_PERIOD     = 8;
   localparam int RAND_PKTS      = 24;
   localparam int MAX_PKT_LEN    = 6;
   localparam int BP_PKTS        = 14;
   // Directed tests stay below this many beats
   localparam int DIRECTED_BEATS = 60;
   localparam int TOTAL_BEATS    = DIRECTED_BEATS + RAND_PKTS * MAX_PKT_LEN + BP_PKTS;

   logic       clk = 1'b0;
   logic       rst_n;
   logic       beat_valid;
   scan_beat_t beat;
   logic       beat_credit;
   logic       verdict_valid;
   verdict_t   verdict;
   logic       verdict_credit = 1'b0;

   // Upstream bookkeeping
   int beats_sent;
   int credits_back;
   int pkts_sent;
   // Downstream bookkeeping
   int verdicts_seen;
   int credits_granted = VERDICT_CREDITS;
   int credits_owed;
   bit consumer_paused;
   bit use_gaps;
   logic [31:0] gap_lfsr  = 32'h10eb59ba;
   logic [31:0] stim_lfsr = 32'h10eb59ba;

   // Reference model with the state as the count of pattern bytes matched
   string pattern_str = "cmd.exe";
   int m_saved [CTX_DEPTH];
   int m_work;
   logic m_flag;
   logic [COUNT_W-1:0] m_count;
   verdict_t exp_q [$];

   int checks;
   int errors;
   string cur_test;

   pattern_scanner_top dut_i (
      .clk            (clk),
      .rst_n          (rst_n),
      .beat_valid     (beat_valid),
      .beat           (beat),
      .beat_credit    (beat_credit),
      .verdict_valid  (verdict_valid),
      .verdict        (verdict),
      .verdict_credit (verdict_credit)
   );

   initial
   begin
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Run limit scales with the traffic of all tests
   initial
   begin
      #((TOTAL_BEATS + 50) * 20 * CLK_PERIOD);
      $display("Timeout: traffic did not complete, %0d errors so far", errors);
      $display("Simulation FAILED");
      $finish;
   end

   // 32-bit Fibonacci LFSR with taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic int rand_bits(input int n);
      int v;
      v = 0;
      for (int i = 0; i < n; i++)
      begin
         stim_lfsr = lfsr_next(stim_lfsr);
         v = (v << 1) | int'(stim_lfsr[0]);
      end
      return v;
   endfunction

   task automatic check_verdict(input string name, input verdict_t exp, input verdict_t act);
      checks++;
      if (act !== exp)
      begin
         errors++;
         $write("CHECK FAILED %s: expected sid=%0d en=%0b m=%0b cnt=%0d", name,
                exp.stream_id, exp.enabled, exp.matched, exp.match_count);
         $display(" actual sid=%0d en=%0b m=%0b cnt=%0d",
                  act.stream_id, act.enabled, act.matched, act.match_count);
      end
   endtask

   task automatic check_credit_total(input string name, input int exp, input int act);
      checks++;
      if (act != exp)
      begin
         errors++;
         $display("CHECK FAILED %s: expected %0d actual %0d", name, exp, act);
      end
   endtask

   // One byte through the model automaton with the verdict queued at eop
   task automatic model_beat(input scan_beat_t b);
      int st;
      logic acc;
      logic [7:0] restart;
      verdict_t v;
      acc = 1'b0;
      st  = b.sop ? (b.new_stream ? 0 : m_saved[b.stream_id]) : m_work;
      if (b.sop)
         m_flag = 1'b0;
      restart = (b.data == 8'h63) ? 8'd1 : 8'd0;
      if (b.data == pattern_str[st])
      begin
         if (st == PATTERN_LEN - 1)
         begin
            acc = 1'b1;
            st  = int'(restart);
         end
         else
            st++;
      end
      else
         st = int'(restart);
      m_flag = m_flag | acc;
      m_work = st;
      if (b.eop)
      begin
         v.stream_id = b.stream_id;
         v.enabled   = b.enable;
         v.matched   = b.enable && m_flag;
         if (v.matched)
            m_count++;
         v.match_count = m_count;
         if (b.enable)
            m_saved[b.stream_id] = st;
         exp_q.push_back(v);
      end
   endtask

   // Sender holds INGRESS_DEPTH credits minus beats still in the DUT
   task automatic send_beat(input scan_beat_t b);
      @(negedge clk);
      while (INGRESS_DEPTH + credits_back - beats_sent <= 0)
      begin
         beat_valid = 1'b0;
         @(negedge clk);
      end
      beat       = b;
      beat_valid = 1'b1;
      beats_sent++;
      model_beat(b);
   endtask

   task automatic send_packet(input string payload, input logic [STREAM_W-1:0] sid,
                              input logic new_s, input logic en);
      scan_beat_t b;
      for (int i = 0; i < payload.len(); i++)
      begin
         b.data       = payload[i];
         b.stream_id  = sid;
         b.sop        = (i == 0);
         b.eop        = (i == payload.len() - 1);
         b.new_stream = new_s;
         b.enable     = en;
         send_beat(b);
      end
      pkts_sent++;
      @(negedge clk);
      beat_valid = 1'b0;
   endtask

   task automatic wait_drain();
      while (exp_q.size() != 0)
         @(negedge clk);
   endtask

   // Upstream credit pulses
   always @(posedge clk)
   begin
      if (rst_n && beat_credit)
         credits_back++;
   end

   // Verdict consumer where each verdict owes one credit back
   always @(posedge clk)
   begin
      if (rst_n && verdict_valid)
      begin
         verdicts_seen++;
         if (verdicts_seen > credits_granted)
         begin
            errors++;
            $display("ERROR %s: verdict sent without downstream credit", cur_test);
         end
         if (exp_q.size() == 0)
         begin
            errors++;
            $display("ERROR %s: verdict arrived with none expected", cur_test);
         end
         else
            check_verdict(cur_test, exp_q.pop_front(), verdict);
         credits_owed++;
      end
   end

   // Credit return that can be paused or thinned out by LFSR gaps
   always @(negedge clk)
   begin
      logic gap_bit;
      gap_bit        = 1'b1;
      verdict_credit = 1'b0;
      if (use_gaps)
      begin
         gap_lfsr = lfsr_next(gap_lfsr);
         gap_bit  = gap_lfsr[0];
      end
      if (rst_n && !consumer_paused && credits_owed > 0 && gap_bit)
      begin
         verdict_credit = 1'b1;
         credits_owed--;
         credits_granted++;
      end
   end

   task automatic single_packet_match();
      cur_test = "single_packet_match";
      send_packet("xxcmd.exe", 6'd1, 1'b1, 1'b1);
      send_packet("hello", 6'd1, 1'b0, 1'b1);
      wait_drain();
   endtask

   task automatic cross_packet_match();
      cur_test = "cross_packet_match";
      send_packet("..cm", 6'd5, 1'b1, 1'b1);
      send_packet("d.exe", 6'd5, 1'b0, 1'b1);
      // New stream drops the saved prefix
      send_packet("..cm", 6'd5, 1'b1, 1'b1);
      send_packet("d.exe", 6'd5, 1'b1, 1'b1);
      wait_drain();
   endtask

   task automatic disabled_packet();
      cur_test = "disabled_packet";
      send_packet("xcm", 6'd9, 1'b1, 1'b1);
      send_packet("cmd.exe", 6'd9, 1'b0, 1'b0);
      // Continues from "cm" saved before the disabled packet
      send_packet("d.exe", 6'd9, 1'b0, 1'b1);
      wait_drain();
   endtask

   task automatic interleaved_streams();
      bit seen [8];
      int idx;
      int start;
      int last;
      string payload;
      logic new_s;
      logic en;
      cur_test = "interleaved_streams";
      use_gaps = 1'b1;
      for (int p = 0; p < RAND_PKTS; p++)
      begin
         idx = rand_bits(3);
         // Half the time continue the fragment where the stream stopped
         start = rand_bits(1) ? m_saved[8 + idx] : rand_bits(3) % PATTERN_LEN;
         last  = start + rand_bits(2);
         if (last > PATTERN_LEN - 1)
            last = PATTERN_LEN - 1;
         if (rand_bits(1))
            payload = "x";
         else
            payload = "";
         payload = {payload, pattern_str.substr(start, last)};
         new_s   = !seen[idx] || (rand_bits(3) == 0);
         en      = (rand_bits(2) != 0);
         seen[idx] = 1'b1;
         send_packet(payload, 6'(8 + idx), new_s, en);
      end
      wait_drain();
      use_gaps = 1'b0;
   endtask

   task automatic backpressure();
      int quiet;
      int bp_start;
      cur_test        = "backpressure";
      consumer_paused = 1'b1;
      bp_start        = beats_sent;
      fork
         begin
            // One byte per packet so the pattern spans packets twice
            for (int i = 0; i < BP_PKTS; i++)
               send_packet(pattern_str.substr(i % PATTERN_LEN, i % PATTERN_LEN),
                           6'd20, i == 0, 1'b1);
         end
         begin
            quiet = 0;
            while (quiet < 16 || beats_sent - bp_start < INGRESS_DEPTH)
            begin
               @(posedge clk);
               if (beat_credit || verdict_valid)
                  quiet = 0;
               else
                  quiet++;
            end
            check_credit_total("backpressure upstream held", INGRESS_DEPTH,
                               beats_sent - credits_back);
            if (beats_sent - bp_start >= BP_PKTS)
            begin
               errors++;
               $display("ERROR backpressure: upstream never stalled");
            end
            consumer_paused = 1'b0;
         end
      join
      wait_drain();
   endtask

   task automatic credit_accounting();
      int n;
      int quiet;
      int seen_before;
      cur_test = "credit_accounting";
      n = 0;
      while (credits_owed != 0 && n < 50)
      begin
         @(posedge clk);
         n++;
      end
      // Every credit is back, so only the initial grant may leave while paused
      consumer_paused = 1'b1;
      seen_before     = verdicts_seen;
      for (int i = 0; i <= VERDICT_CREDITS; i++)
         send_packet("z", 6'd30, i == 0, 1'b1);
      quiet = 0;
      while (quiet < 16)
      begin
         @(posedge clk);
         if (beat_credit || verdict_valid)
            quiet = 0;
         else
            quiet++;
      end
      check_credit_total("credit_accounting verdicts within grant", VERDICT_CREDITS,
                         verdicts_seen - seen_before);
      consumer_paused = 1'b0;
      wait_drain();
      n = 0;
      while ((credits_back != beats_sent || credits_owed != 0) && n < 50)
      begin
         @(posedge clk);
         n++;
      end
      check_credit_total("credit_accounting beat credits", beats_sent, credits_back);
      check_credit_total("credit_accounting verdicts", pkts_sent, verdicts_seen);
   endtask

   initial
   begin
      rst_n      = 1'b0;
      beat_valid = 1'b0;
      beat       = '0;
      m_work     = 0;
      m_flag     = 1'b0;
      m_count    = '0;
      foreach (m_saved[i])
         m_saved[i] = 0;
      repeat (2) @(negedge clk);
      rst_n = 1'b1;

      single_packet_match();
      cross_packet_match();
      disabled_packet();
      interleaved_streams();
      backpressure();
      credit_accounting();

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

endmodule

// ==== rtl/pattern_scanner_top.sv ====
module pattern_scanner_top (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 beat_valid,
   input  scan_pkg::scan_beat_t beat,
   output logic                 beat_credit,
   output logic                 verdict_valid,
   output scan_pkg::verdict_t   verdict,
   input  logic                 verdict_credit
);

   import scan_pkg::*;

   logic       proc_valid;
   scan_beat_t proc_beat;
   logic       verdict_room;
   logic       verdict_push;
   verdict_t   verdict_int;

   // Beat buffer, held back while the verdict queue is full
   scan_ingress scan_ingress_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .beat_valid   (beat_valid),
      .beat         (beat),
      .beat_credit  (beat_credit),
      .verdict_room (verdict_room),
      .proc_valid   (proc_valid),
      .proc_beat    (proc_beat)
   );

   // Per-stream matching and counting
   stream_context stream_context_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .proc_valid   (proc_valid),
      .proc_beat    (proc_beat),
      .verdict_push (verdict_push),
      .verdict_out  (verdict_int)
   );

   verdict_egress verdict_egress_i (
      .clk            (clk),
      .rst_n          (rst_n),
      .verdict_push   (verdict_push),
      .verdict_in     (verdict_int),
      .verdict_room   (verdict_room),
      .verdict_credit (verdict_credit),
      .verdict_valid  (verdict_valid),
      .verdict        (verdict)
   );

endmodule

// ==== rtl/verdict_egress.sv ====
module verdict_egress (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               verdict_push,
   input  scan_pkg::verdict_t verdict_in,
   output logic               verdict_room,
   input  logic               verdict_credit,
   output logic               verdict_valid,
   output scan_pkg::verdict_t verdict
);

   import scan_pkg::*;

   localparam int PTR_W  = $clog2(EGRESS_DEPTH);
   // One spare bit so an excess credit shows up
   localparam int CRED_W = $clog2(VERDICT_CREDITS + 1) + 1;

   verdict_t          q_mem [EGRESS_DEPTH];
   logic [PTR_W-1:0]  wr_ptr;
   logic [PTR_W-1:0]  rd_ptr;
   logic [PTR_W:0]    fill;
   logic [CRED_W-1:0] credits;

   // Room for the verdict an admitted beat may push this cycle
   assign verdict_room  = fill != (PTR_W+1)'(EGRESS_DEPTH);
   // Send only with a queued verdict and a credit in hand
   assign verdict_valid = (fill != '0) && (credits != '0);
   assign verdict       = q_mem[rd_ptr];

   always_ff @(posedge clk)
   begin
      if (verdict_push)
         q_mem[wr_ptr] <= verdict_in;
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         fill    <= '0;
         credits <= CRED_W'(VERDICT_CREDITS);
      end
      else
      begin
         if (verdict_push)
            wr_ptr <= wr_ptr + PTR_W'(1);
         if (verdict_valid)
            rd_ptr <= rd_ptr + PTR_W'(1);
         fill    <= fill + (PTR_W+1)'(verdict_push) - (PTR_W+1)'(verdict_valid);
         credits <= credits + CRED_W'(verdict_credit) - CRED_W'(verdict_valid);
      end
   end

   // Ingress admitted a beat without room for its verdict
   a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
      verdict_push |-> fill != (PTR_W+1)'(EGRESS_DEPTH));

   // Consumer returned more credits than it was given
   a_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
      credits <= CRED_W'(VERDICT_CREDITS));

endmodule

// ==== rtl/stream_context.sv ====
module stream_context (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 proc_valid,
   input  scan_pkg::scan_beat_t proc_beat,
   output logic                 verdict_push,
   output scan_pkg::verdict_t   verdict_out
);

   import scan_pkg::*;
   import dfa_pkg::*;

   // Saved automaton state per stream
   ctx_t                ctx_mem [CTX_DEPTH];
   // Context of the packet being scanned
   ctx_t                work;
   logic [STREAM_W-1:0] cur_stream;
   logic                match_flag;
   logic [COUNT_W-1:0]  match_count;

   dfa_state_e          start_state;
   dfa_state_e          next_state;
   logic                accept;
   logic                flag_next;
   logic                pkt_hit;
   logic [COUNT_W-1:0]  count_next;

   // Engine input
   // sop restores the stream, or starts clean for a new stream
   always_comb
   begin
      if (proc_beat.sop)
         start_state = proc_beat.new_stream ? S_IDLE : ctx_mem[proc_beat.stream_id].state;
      else
         start_state = work.state;
   end

   dfa_engine dfa_engine_i (
      .cur_state  (start_state),
      .data       (proc_beat.data),
      .next_state (next_state),
      .accept     (accept)
   );

   // Flag starts over at sop, then collects any accept in the packet
   assign flag_next  = (proc_beat.sop ? 1'b0 : match_flag) | accept;
   // Disabled packets never count
   assign pkt_hit    = proc_beat.enable && flag_next;
   assign count_next = match_count + COUNT_W'(pkt_hit);

   // Verdict goes out with the eop beat
   assign verdict_push            = proc_valid && proc_beat.eop;
   assign verdict_out.stream_id   = proc_beat.stream_id;
   assign verdict_out.enabled     = proc_beat.enable;
   assign verdict_out.matched     = pkt_hit;
   assign verdict_out.match_count = count_next;

   always_ff @(posedge clk)
   begin
      if (proc_valid && proc_beat.sop)
         cur_stream <= proc_beat.stream_id;
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         work        <= '{state: S_IDLE, in_packet: 1'b0};
         match_flag  <= 1'b0;
         match_count <= '0;
         for (int i = 0; i < CTX_DEPTH; i++)
         begin
            ctx_mem[i] <= '{state: S_IDLE, in_packet: 1'b0};
         end
      end
      else if (proc_valid)
      begin
         work.state     <= next_state;
         work.in_packet <= !proc_beat.eop;
         match_flag     <= flag_next;
         if (proc_beat.eop)
         begin
            match_count <= count_next;
            // Only enabled packets carry their state forward
            if (proc_beat.enable)
               ctx_mem[proc_beat.stream_id] <= '{state: next_state, in_packet: 1'b0};
         end
      end
   end

   // Body beat without a packet open
   a_body_in_packet: assert property (@(posedge clk) disable iff (!rst_n)
      proc_valid && !proc_beat.sop |-> work.in_packet);

   // Streams must not interleave inside a packet
   a_same_stream: assert property (@(posedge clk) disable iff (!rst_n)
      proc_valid && !proc_beat.sop && work.in_packet |-> proc_beat.stream_id == cur_stream);

endmodule

// ==== rtl/scan_ingress.sv ====
module scan_ingress (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 beat_valid,
   input  scan_pkg::scan_beat_t beat,
   output logic                 beat_credit,
   input  logic                 verdict_room,
   output logic                 proc_valid,
   output scan_pkg::scan_beat_t proc_beat
);

   import scan_pkg::*;

   localparam int PTR_W = $clog2(INGRESS_DEPTH);

   // Circular beat buffer, payload only
   scan_beat_t       q_mem [INGRESS_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   // Occupancy, one extra bit to hold the full count
   logic [PTR_W:0]   fill;
   logic             pop;

   // Present the head beat only if the verdict side can take a result
   assign proc_valid = (fill != '0) && verdict_room;
   assign proc_beat  = q_mem[rd_ptr];
   // The context block always consumes a presented beat
   assign pop        = proc_valid;

   always_ff @(posedge clk)
   begin
      if (beat_valid)
      begin
         q_mem[wr_ptr] <= beat;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         wr_ptr      <= '0;
         rd_ptr      <= '0;
         fill        <= '0;
         beat_credit <= 1'b0;
      end
      else
      begin
         if (beat_valid)
            wr_ptr <= wr_ptr + PTR_W'(1);
         if (pop)
            rd_ptr <= rd_ptr + PTR_W'(1);
         fill <= fill + (PTR_W+1)'(beat_valid) - (PTR_W+1)'(pop);
         // Freed entry goes back upstream one cycle after the pop
         beat_credit <= pop;
      end
   end

   // Sender wrote without a credit
   a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
      beat_valid |-> fill != (PTR_W+1)'(INGRESS_DEPTH));

endmodule

// ==== rtl/dfa_engine.sv ====
module dfa_engine (
   input  dfa_pkg::dfa_state_e cur_state,
   input  logic [7:0]          data,
   output dfa_pkg::dfa_state_e next_state,
   output logic                accept
);

   import dfa_pkg::*;

   // Expected byte for each state, indexed by bytes already matched
   localparam logic [7:0] PATTERN [PATTERN_LEN] = '{
      8'h63,   // c
      8'h6d,   // m
      8'h64,   // d
      8'h2e,   // .
      8'h65,   // e
      8'h78,   // x
      8'h65    // e
   };

   // State holding the last pattern byte still to come
   localparam dfa_state_e LAST_STATE = dfa_state_e'(PATTERN_LEN - 1);

   logic [7:0] expected;
   logic       hit;
   dfa_state_e restart;

   assign expected = PATTERN[cur_state];
   assign hit      = (data == expected);

   // 'c' occurs only at the head of the pattern
   // So any restart keeps at most that one byte
   assign restart = (data == PATTERN[0]) ? S_C : S_IDLE;

   always_comb
   begin
      accept     = 1'b0;
      next_state = restart;
      if (hit)
      begin
         if (cur_state == LAST_STATE)
         begin
            // Full pattern seen, start over for overlapping searches
            accept     = 1'b1;
            next_state = restart;
         end
         else
         begin
            next_state = dfa_state_e'(cur_state + 3'd1);
         end
      end
   end

endmodule

// ==== rtl/scan_pkg.sv ====
package scan_pkg;

   // Transport types shared by the ingress, context and egress blocks

   // Stream id width, 64 streams
   localparam int STREAM_W = 6;

   // Input beat queue depth
   // Also the number of credits the sender holds after reset
   localparam int INGRESS_DEPTH = 4;

   // Verdict queue depth
   localparam int EGRESS_DEPTH = 4;

   // Credits granted by the downstream consumer after reset
   localparam int VERDICT_CREDITS = 2;

   // One payload byte with its framing flags
   typedef struct packed {
      logic [7:0]          data;
      logic [STREAM_W-1:0] stream_id;
      logic                sop;
      logic                eop;
      // Only looked at on sop
      logic                new_stream;
      // Only looked at on eop
      logic                enable;
   } scan_beat_t;

   // One result per packet
   typedef struct packed {
      logic [STREAM_W-1:0]         stream_id;
      logic                        enabled;
      logic                        matched;
      // Counter value after this packet, same width as the context counter
      logic [dfa_pkg::COUNT_W-1:0] match_count;
   } verdict_t;

endpackage

// ==== rtl/dfa_pkg.sv ====
package dfa_pkg;

   // Automaton and stream context definitions

   // Length of the literal "cmd.exe"
   localparam int PATTERN_LEN = 7;

   // Matched-packet counter width
   localparam int COUNT_W = 16;

   // Number of saved stream contexts, one per stream id
   localparam int CTX_DEPTH = 64;

   // State index is the number of pattern bytes matched so far
   typedef enum logic [2:0] {
      S_IDLE = 3'd0,
      S_C    = 3'd1,
      S_CM   = 3'd2,
      S_CMD  = 3'd3,
      S_DOT  = 3'd4,
      S_E    = 3'd5,
      S_EX   = 3'd6
   } dfa_state_e;

   // Context of one stream
   // in_packet is set between sop and eop of the working packet
   typedef struct packed {
      dfa_state_e state;
      logic       in_packet;
   } ctx_t;

endpackage
